// ==== hdl/dma_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_dma_consts.svh"

module dma_regs (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire rx_dma_pkg::reg_addr_t reg_addr,
	input  wire rx_dma_pkg::reg_data_t reg_wdata,
	input  wire                        reg_we,
	output rx_dma_pkg::reg_data_t      reg_rdata,
	output logic                       dma_enable,
	output logic                       irq_enable,
	output rx_dma_pkg::dw_addr_t       buf_start,
	output rx_dma_pkg::dw_addr_t       buf_length,
	output logic                       load_req,
	input  wire                        load_ack,
	input  wire rx_dma_pkg::dw_addr_t  cur_ptr
);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			dma_enable <= 1'b0;
			irq_enable <= 1'b0;
			buf_start <= '0;
			buf_length <= '0;
		end else if (reg_we) begin
			case (reg_addr)
				`REG_CTRL: begin
					dma_enable <= reg_wdata[0];
					irq_enable <= reg_wdata[1];
				end
				`REG_START:  buf_start <= reg_wdata[31:2];
				`REG_LENGTH: buf_length <= reg_wdata[31:2];  // Bytes, dword aligned
				default: ;  // Current pointer is read only
			endcase
		end
	end

	// Pointer reload waits until the engine is idle
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			load_req <= 1'b0;
		else if (reg_we && reg_addr == `REG_START)
			load_req <= 1'b1;
		else if (load_ack)
			load_req <= 1'b0;
	end

	always_comb begin
		case (reg_addr)
			`REG_CTRL:   reg_rdata = {30'd0, irq_enable, dma_enable};
			`REG_START:  reg_rdata = {buf_start, 2'b00};
			`REG_LENGTH: reg_rdata = {buf_length, 2'b00};
			`REG_CUR:    reg_rdata = {cur_ptr, 2'b00};
			default:     reg_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
	input  wire                    sys_clk,
	input  wire                    sys_rst,
	input  wire [15:0]             rx_data,
	input  wire                    rx_last,
	input  wire                    rx_valid,
	output logic                   rx_ready,
	output rx_dma_pkg::fifo_word_t data_din,
	output logic                   data_wr_en,
	input  wire                    data_full,
	output rx_dma_pkg::len_word_t  len_din,
	output logic                   len_wr_en,
	input  wire                    len_full
);

	import rx_dma_pkg::*;

	frame_len_t byte_cnt;     // Bytes taken before this word
	frame_len_t frame_bytes;
	logic accept;

	// Stall the source while either queue is full
	assign rx_ready = !data_full && !len_full;
	assign accept = rx_valid && rx_ready;

	assign frame_bytes = byte_cnt + 11'd2;

	assign data_din = {1'b1, ~rx_last, rx_data};
	assign data_wr_en = accept;

	assign len_din = {1'b1, 6'b000000, frame_bytes};
	assign len_wr_en = accept && rx_last;  // Length goes with the last word

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			byte_cnt <= '0;
		end else if (accept) begin
			if (rx_last)
				byte_cnt <= '0;
			else
				byte_cnt <= frame_bytes;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rx_dma_consts.svh ====
`ifndef RX_DMA_CONSTS_SVH
`define RX_DMA_CONSTS_SVH

// Largest write request in dwords
`define TLP_MAX_DW 32

`define DATA_FIFO_DEPTH 1024
`define LEN_FIFO_DEPTH  16
`define MST_FIFO_DEPTH  64

`define REG_CTRL   4'd0
`define REG_START  4'd1
`define REG_LENGTH 4'd2
`define REG_CUR    4'd3

`define TAG_HDR  2'b10
`define TAG_DATA 2'b00
`define TAG_LAST 2'b01  // Final halfword of a request

`define MARK_LO 16'h5555
`define MARK_HI 16'h555d

`endif

// ==== hdl/rx_dma_pkg.sv ====
`default_nettype none

package rx_dma_pkg;

	// Tag in 17:16, payload below
	typedef logic [17:0] mst_word_t;

	// Valid, more-follows, data
	typedef logic [17:0] fifo_word_t;

	typedef logic [17:0] len_word_t;  // Entry marker in 17, count in 10:0

	typedef logic [29:0] dw_addr_t;   // Host address bits 31:2
	typedef logic [10:0] frame_len_t;
	typedef logic [9:0]  dw_count_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [3:0]  reg_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		HEAD0,
		HEAD1,
		HEAD2,
		PREFIX,
		SKIP,
		DATA,
		FIN
	} rx_state_t;

endpackage

`default_nettype wire

// ==== hdl/rx_dma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_dma_consts.svh"

module rx_dma_top (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire [15:0]                 rx_data,
	input  wire                        rx_last,
	input  wire                        rx_valid,
	output logic                       rx_ready,
	output rx_dma_pkg::mst_word_t      mst_data,
	output logic                       mst_valid,
	input  wire                        mst_ready,
	input  wire rx_dma_pkg::reg_addr_t reg_addr,
	input  wire rx_dma_pkg::reg_data_t reg_wdata,
	input  wire                        reg_we,
	output rx_dma_pkg::reg_data_t      reg_rdata,
	output logic                       irq
);

	import rx_dma_pkg::*;

	fifo_word_t data_din;
	fifo_word_t data_dout;
	logic data_wr_en;
	logic data_rd_en;
	logic data_full;
	logic data_empty;
	len_word_t len_din;
	len_word_t len_dout;
	logic len_wr_en;
	logic len_rd_en;
	logic len_full;
	logic len_empty;
	mst_word_t mst_din;
	logic mst_wr_en;
	logic mst_full;
	logic mst_empty;
	logic dma_enable;
	logic irq_enable;
	dw_addr_t buf_start;
	dw_addr_t buf_length;
	dw_addr_t cur_ptr;
	logic load_req;
	logic load_ack;

	assign mst_valid = !mst_empty;

	frame_buffer u_frame_buffer (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.rx_data(rx_data), .rx_last(rx_last), .rx_valid(rx_valid), .rx_ready(rx_ready),
		.data_din(data_din), .data_wr_en(data_wr_en), .data_full(data_full),
		.len_din(len_din), .len_wr_en(len_wr_en), .len_full(len_full)
	);

	sync_fifo #(.WIDTH($bits(fifo_word_t)), .DEPTH(`DATA_FIFO_DEPTH)) u_data_fifo (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.din(data_din), .wr_en(data_wr_en), .full(data_full),
		.dout(data_dout), .rd_en(data_rd_en), .empty(data_empty)
	);

	sync_fifo #(.WIDTH($bits(len_word_t)), .DEPTH(`LEN_FIFO_DEPTH)) u_len_fifo (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.din(len_din), .wr_en(len_wr_en), .full(len_full),
		.dout(len_dout), .rd_en(len_rd_en), .empty(len_empty)
	);

	// Outbound requests, popped by the link side
	sync_fifo #(.WIDTH($bits(mst_word_t)), .DEPTH(`MST_FIFO_DEPTH)) u_mst_fifo (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.din(mst_din), .wr_en(mst_wr_en), .full(mst_full),
		.dout(mst_data), .rd_en(mst_ready), .empty(mst_empty)
	);

	dma_regs u_dma_regs (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we), .reg_rdata(reg_rdata),
		.dma_enable(dma_enable), .irq_enable(irq_enable),
		.buf_start(buf_start), .buf_length(buf_length),
		.load_req(load_req), .load_ack(load_ack), .cur_ptr(cur_ptr)
	);

	tlp_write_engine u_tlp_write_engine (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.data_dout(data_dout), .data_empty(data_empty), .data_rd_en(data_rd_en),
		.len_dout(len_dout), .len_empty(len_empty), .len_rd_en(len_rd_en),
		.mst_din(mst_din), .mst_wr_en(mst_wr_en), .mst_full(mst_full),
		.dma_enable(dma_enable), .irq_enable(irq_enable),
		.buf_start(buf_start), .buf_length(buf_length),
		.load_req(load_req), .load_ack(load_ack), .cur_ptr(cur_ptr),
		.irq(irq)
	);

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 18,
	parameter int DEPTH = 16
) (
	input  wire              sys_clk,
	input  wire              sys_rst,
	input  wire [WIDTH-1:0]  din,
	input  wire              wr_en,
	output logic             full,
	output logic [WIDTH-1:0] dout,
	input  wire              rd_en,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign dout = mem[rd_ptr];  // Head word shows without a read
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge sys_clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tlp_write_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_dma_consts.svh"

module tlp_write_engine (
	input  wire                         sys_clk,
	input  wire                         sys_rst,
	input  wire rx_dma_pkg::fifo_word_t data_dout,
	input  wire                         data_empty,
	output logic                        data_rd_en,
	input  wire rx_dma_pkg::len_word_t  len_dout,
	input  wire                         len_empty,
	output logic                        len_rd_en,
	output rx_dma_pkg::mst_word_t       mst_din,
	output logic                        mst_wr_en,
	input  wire                         mst_full,
	input  wire                         dma_enable,
	input  wire                         irq_enable,
	input  wire rx_dma_pkg::dw_addr_t   buf_start,
	input  wire rx_dma_pkg::dw_addr_t   buf_length,
	input  wire                         load_req,
	output logic                        load_ack,
	output rx_dma_pkg::dw_addr_t        cur_ptr,
	output logic                        irq
);

	import rx_dma_pkg::*;

	rx_state_t state;
	frame_len_t frame_len;
	dw_count_t total_dw;    // Record dwords still to send
	dw_count_t tlp_hw;      // Halfwords left in this request
	dw_count_t req_dw;
	dw_addr_t ptr;
	dw_addr_t ring_top;
	dw_addr_t ring_end;
	dw_addr_t ptr_next;
	dw_addr_t ptr_round;
	dw_addr_t ptr_fin;
	logic [1:0] pfx_idx;
	logic pfx_done;
	logic pay_done;         // Last payload word already taken
	logic data_ok;
	logic hw_step;
	logic [1:0] hw_tag;
	logic [15:0] pfx_word;
	logic [11:0] rec_sum;

	assign ring_top = buf_start + buf_length;
	assign ring_end = ring_top - 30'd1;
	assign ptr_next = (ptr == ring_end) ? buf_start : ptr + 30'd1;

	// Up to the next 16-byte boundary, back to start at the ring top
	assign ptr_round = {ptr[29:2] + {27'd0, |ptr[1:0]}, 2'b00};
	assign ptr_fin = (ptr_round == ring_top) ? buf_start : ptr_round;

	assign req_dw = (total_dw > `TLP_MAX_DW) ? dw_count_t'(`TLP_MAX_DW) : total_dw;
	assign rec_sum = {1'b0, len_dout[10:0]} + 12'd11;  // Prefix plus pad, in bytes

	assign data_ok = !data_empty && data_dout[17];
	assign hw_tag = (tlp_hw == 10'd1) ? `TAG_LAST : `TAG_DATA;
	assign hw_step = mst_wr_en && (state == PREFIX || state == DATA);

	assign len_rd_en = (state == IDLE) && !len_empty;
	assign load_ack = (state == IDLE) && len_empty && load_req;

	always_comb begin
		case (pfx_idx)
			2'd0:    pfx_word = {frame_len[7:0], 5'b00000, frame_len[10:8]};
			2'd1:    pfx_word = 16'h0000;
			2'd2:    pfx_word = `MARK_LO;
			default: pfx_word = `MARK_HI;
		endcase
	end

	always_comb begin
		mst_din = {`TAG_DATA, 16'h0000};
		mst_wr_en = 1'b0;
		data_rd_en = 1'b0;
		case (state)
			HEAD0: begin
				mst_din = {`TAG_HDR, 2'b10, req_dw[5:0], 8'hff};  // Memory write
				mst_wr_en = !mst_full;
			end
			HEAD1: begin
				mst_din = {`TAG_DATA, ptr[29:14]};
				mst_wr_en = !mst_full;
			end
			HEAD2: begin
				mst_din = {`TAG_DATA, ptr[13:0], 2'b00};
				mst_wr_en = !mst_full;
			end
			PREFIX: begin
				mst_din = {hw_tag, pfx_word};
				mst_wr_en = !mst_full;
			end
			DATA: begin
				mst_din = {hw_tag, pay_done ? 16'h0000 : data_dout[15:0]};
				mst_wr_en = !mst_full && (pay_done || data_ok);
				// Words without the valid bit are dropped
				data_rd_en = !pay_done && !data_empty && (!data_dout[17] || !mst_full);
			end
			SKIP: data_rd_en = !data_empty;
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= IDLE;
			frame_len <= '0;
			total_dw <= '0;
			tlp_hw <= '0;
			ptr <= '0;
			cur_ptr <= '0;
			pfx_idx <= '0;
			pfx_done <= 1'b0;
			pay_done <= 1'b0;
			irq <= 1'b0;
		end else begin
			irq <= 1'b0;
			if (hw_step) begin
				tlp_hw <= tlp_hw - 10'd1;
				if (tlp_hw[0]) begin  // Dword complete
					ptr <= ptr_next;
					total_dw <= total_dw - 10'd1;
				end
			end
			case (state)
				IDLE: begin
					if (!len_empty) begin
						if (len_dout[17]) begin
							frame_len <= len_dout[10:0];
							total_dw <= rec_sum[11:2];
							pfx_idx <= '0;
							pfx_done <= 1'b0;
							pay_done <= 1'b0;
							state <= dma_enable ? HEAD0 : SKIP;  // Enable held per frame
						end
					end else if (load_req) begin
						ptr <= buf_start;
						cur_ptr <= buf_start;
					end
				end
				HEAD0: begin
					if (!mst_full) begin
						tlp_hw <= {req_dw[8:0], 1'b0};
						state <= HEAD1;
					end
				end
				HEAD1: if (!mst_full) state <= HEAD2;
				HEAD2: begin
					if (!mst_full)
						state <= pfx_done ? DATA : PREFIX;
				end
				PREFIX: begin
					if (hw_step) begin
						pfx_idx <= pfx_idx + 2'd1;
						if (pfx_idx == 2'd3) begin
							pfx_done <= 1'b1;
							state <= DATA;
						end
					end
				end
				DATA: begin
					if (data_rd_en && data_dout[17] && !data_dout[16])
						pay_done <= 1'b1;
					if (hw_step && tlp_hw == 10'd1)
						state <= (total_dw == 10'd1) ? FIN : HEAD0;
				end
				SKIP: begin
					// Drain a frame taken while disabled
					if (data_ok && !data_dout[16])
						state <= IDLE;
				end
				FIN: begin
					ptr <= ptr_fin;
					cur_ptr <= ptr_fin;
					irq <= irq_enable;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
+incdir+testbench
hdl/rx_dma_pkg.sv
hdl/sync_fifo.sv
hdl/frame_buffer.sv
hdl/dma_regs.sv
hdl/tlp_write_engine.sv
hdl/rx_dma_top.sv
testbench/tb_rx_dma.sv

// ==== testbench/tb_rx_dma_tasks.svh ====
task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		$display("tests failed");
		$fatal(1, "stopping at first mismatch");
	end
endtask

task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
	@(posedge sys_clk);
	#1;
	reg_addr = addr;
	reg_wdata = data;
	reg_we = 1'b1;
	@(posedge sys_clk);
	#1;
	reg_we = 1'b0;
endtask

task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
	@(posedge sys_clk);
	#1;
	reg_addr = addr;
	@(negedge sys_clk);
	data = reg_rdata;
endtask

// Reference record: prefix, payload, pad, then split at the request limit
task automatic model_record(input int nbytes);
	logic [15:0] rec [$];
	logic [10:0] blen;
	int left;
	int n;
	int pos;
	blen = nbytes[10:0];
	rec.push_back({blen[7:0], 5'b00000, blen[10:8]});
	rec.push_back(16'h0000);
	rec.push_back(`MARK_LO);
	rec.push_back(`MARK_HI);
	foreach (pay_q[i])
		rec.push_back(pay_q[i]);
	if (rec.size() % 2 == 1)
		rec.push_back(16'h0000);
	left = rec.size() / 2;
	pos = 0;
	while (left > 0) begin
		n = (left > `TLP_MAX_DW) ? `TLP_MAX_DW : left;
		exp_q.push_back({`TAG_HDR, 2'b10, 6'(n), 8'hff});
		exp_q.push_back({`TAG_DATA, m_ptr[29:14]});
		exp_q.push_back({`TAG_DATA, m_ptr[13:0], 2'b00});
		for (int k = 0; k < 2 * n; k++) begin
			exp_q.push_back({(k == 2 * n - 1) ? `TAG_LAST : `TAG_DATA, rec[pos]});
			pos++;
			if (k % 2 == 1)  // Dword done
				m_ptr = (m_ptr == m_start + m_len - 1) ? m_start : m_ptr + 1;
		end
		left -= n;
	end
	if (m_ptr % 4 != 0)
		m_ptr = m_ptr + (4 - m_ptr % 4);
	if (m_ptr == m_start + m_len)
		m_ptr = m_start;
endtask

task automatic send_frame(input int nbytes, input bit written);
	int words;
	words = nbytes / 2;
	pay_q.delete();
	for (int i = 0; i < words; i++)
		pay_q.push_back(16'($urandom));
	if (written)
		model_record(nbytes);
	for (int i = 0; i < words; i++) begin
		@(posedge sys_clk);
		#1;
		rx_valid = 1'b1;
		rx_data = pay_q[i];
		rx_last = (i == words - 1);
		@(negedge sys_clk);
		while (!rx_ready)
			@(negedge sys_clk);
	end
	@(posedge sys_clk);
	#1;
	rx_valid = 1'b0;
	rx_last = 1'b0;
endtask

task automatic compare_output();
	int waited;
	int limit;
	waited = 0;
	limit = exp_q.size() * 8 + 200;
	while (got_q.size() < exp_q.size() && waited < limit) begin
		@(negedge sys_clk);
		waited++;
	end
	repeat (8) @(negedge sys_clk);  // Catch stray extra words
	check_eq(got_q.size(), exp_q.size(), "output word count");
	foreach (exp_q[i])
		check_eq(got_q[i], exp_q[i], $sformatf("output word %0d", i));
	got_q.delete();
	exp_q.delete();
endtask

task automatic check_cur_ptr();
	reg_data_t val;
	int tries;
	tries = 0;
	read_reg(`REG_CUR, val);
	while (val !== {m_ptr, 2'b00} && tries < 40) begin
		read_reg(`REG_CUR, val);
		tries++;
	end
	check_eq(val, {m_ptr, 2'b00}, "current pointer");
endtask

task automatic set_ring(input reg_data_t start, input reg_data_t length);
	write_reg(`REG_LENGTH, length);
	write_reg(`REG_START, start);
	m_start = start[31:2];
	m_len = length[31:2];
	m_ptr = m_start;
	check_cur_ptr();
endtask

task automatic run_frame(input int nbytes, input int irq_exp);
	int irq_before;
	irq_before = irq_cnt;
	send_frame(nbytes, 1'b1);
	compare_output();
	check_cur_ptr();
	repeat (2) @(negedge sys_clk);
	check_eq(irq_cnt - irq_before, irq_exp, "irq pulse count");
endtask

// ==== testbench/tb_rx_dma.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rx_dma_consts.svh"

module tb_rx_dma;

	import rx_dma_pkg::*;

	localparam int CLK_PERIOD = 10;
	// Input halfwords of all tests
	localparam int TOTAL_WORDS = 30 + 150 + 3 * 50 + 30 + 6 * 300 + 20 + 20 + 40 + 1023;
	localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 8 + 3000;

	logic sys_clk;
	logic sys_rst;
	logic [15:0] rx_data;
	logic rx_last;
	logic rx_valid;
	logic rx_ready;
	mst_word_t mst_data;
	logic mst_valid;
	logic mst_ready;
	reg_addr_t reg_addr;
	reg_data_t reg_wdata;
	logic reg_we;
	reg_data_t reg_rdata;
	logic irq;

	mst_word_t exp_q [$];
	mst_word_t got_q [$];
	logic [15:0] pay_q [$];
	dw_addr_t m_start;      // Ring as the model sees it
	dw_addr_t m_len;
	dw_addr_t m_ptr;
	int irq_cnt = 0;
	logic ready_gaps;
	reg_data_t rd_val;

	rx_dma_top i_dut (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.rx_data(rx_data), .rx_last(rx_last), .rx_valid(rx_valid), .rx_ready(rx_ready),
		.mst_data(mst_data), .mst_valid(mst_valid), .mst_ready(mst_ready),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we), .reg_rdata(reg_rdata),
		.irq(irq)
	);

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		#1;
		mst_ready = ready_gaps ? ($urandom % 4 != 0) : 1'b1;  // Roughly one stall in four
	end

	// Output collector and irq counter
	always @(negedge sys_clk) begin
		if (mst_valid && mst_ready)
			got_q.push_back(mst_data);
		if (irq)
			irq_cnt <= irq_cnt + 1;
	end

	`include "tb_rx_dma_tasks.svh"

	task automatic check_idle_outputs();
		@(negedge sys_clk);
		check_eq(rx_ready, 1'b1, "rx_ready after reset");
		check_eq(mst_valid, 1'b0, "mst_valid after reset");
		check_eq(irq, 1'b0, "irq after reset");
	endtask

	task automatic single_frame_request();
		set_ring(32'h1234_5000, 32'h0001_0000);
		write_reg(`REG_CTRL, 32'd3);
		run_frame(60, 1);
		read_reg(`REG_CUR, rd_val);
		check_eq(rd_val, 32'h1234_5050, "pointer after 60-byte frame");  // 17 dwords rounded to 20
	endtask

	task automatic ring_wraparound();
		set_ring(32'h0000_2000, 32'd256);
		run_frame(100, 1);
		run_frame(100, 1);
		run_frame(100, 1);
		run_frame(60, 1);
		read_reg(`REG_CUR, rd_val);
		check_eq(rd_val, 32'h0000_20a0, "pointer after ring wrap");
	endtask

	task automatic random_backpressure();
		int irq_before;
		int len;
		set_ring(32'h4000_0000, 32'h0010_0000);
		irq_before = irq_cnt;
		ready_gaps = 1'b1;
		for (int f = 0; f < 6; f++) begin
			len = 2 * (1 + $urandom % 300);
			send_frame(len, 1'b1);
		end
		compare_output();
		ready_gaps = 1'b0;
		check_cur_ptr();
		repeat (2) @(negedge sys_clk);
		check_eq(irq_cnt - irq_before, 6, "irq count of back-to-back frames");
	endtask

	task automatic disabled_frame_drop();
		int irq_before;
		write_reg(`REG_CTRL, 32'd2);  // irq enable stays on
		irq_before = irq_cnt;
		send_frame(80, 1'b0);
		repeat (60) @(negedge sys_clk);
		check_eq(got_q.size(), 0, "words from a disabled frame");
		check_eq(irq_cnt - irq_before, 0, "irq from a disabled frame");
		check_cur_ptr();
		write_reg(`REG_CTRL, 32'd1);
		run_frame(40, 0);
		write_reg(`REG_CTRL, 32'd3);
		run_frame(40, 1);
	endtask

	task automatic start_reload();
		write_reg(`REG_START, 32'h0800_0040);
		m_start = 30'h0200_0010;
		m_ptr = m_start;
		check_cur_ptr();
		run_frame(2046, 1);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
		$display("tests failed");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'h8f65_3c9e));
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		rx_data = '0;
		rx_last = 1'b0;
		rx_valid = 1'b0;
		mst_ready = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		reg_we = 1'b0;
		ready_gaps = 1'b0;
		repeat (2) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		check_idle_outputs();
		single_frame_request();
		run_frame(300, 1);  // 77 dwords as 32, 32 and 13
		ring_wraparound();
		random_backpressure();
		disabled_frame_drop();
		start_reload();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
